//--- Makefile
# Verilator build and run of the tournament predictor testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing -sv -f project.f --top-module tb_predictor -o sim
	./obj_dir/sim > $(LOG) 2>&1; cat $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- logic/bp_pkg.sv
`default_nettype none

// Shared widths and counter encoding for the tournament predictor
package bp_pkg;

    // Program counter width
    localparam int pc_w = 32;

    // Branch slot comes straight from the low PC bits
    localparam int slot_w = 6;
    localparam int num_slots = 2**slot_w; // 64 branch slots

    // Local taken/not-taken history kept per slot
    localparam int hist_w = 4;

    // Local pattern table is indexed by {slot, history}
    localparam int lpht_idx_w = slot_w + hist_w;

    // Two-bit saturating counter states
    // The upper bit is the predicted direction
    typedef enum logic [1:0] {
        strong_not_taken = 2'b00,
        weak_not_taken   = 2'b01,
        weak_taken       = 2'b10,
        strong_taken     = 2'b11
    } ctr_state_t;

    // Every counter entry starts here out of reset,
    // so each table initially leans toward not taken
    localparam ctr_state_t ctr_reset = weak_not_taken;

endpackage

`default_nettype wire

//--- logic/counter_table.sv
`timescale 1ns/100ps
`default_nettype none

// Table of 2-bit saturating counters
// Used for the local pattern table, the bimodal table and the chooser
module counter_table #(
    parameter int idx_w = 6
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             upd_en,
    input  logic [idx_w-1:0] rd_index,
    input  logic [idx_w-1:0] upd_index,
    input  logic             upd_taken,
    output logic             rd_taken,
    output logic             upd_pred
);

    import bp_pkg::*;

    localparam int entries = 2**idx_w;

    // Counter storage
    ctr_state_t ctr_mem [entries];

    // Addressed counter on the update side and its next state
    ctr_state_t upd_state;
    ctr_state_t upd_state_next;

    assign upd_state = ctr_mem[upd_index];

    // Saturating step toward the resolved direction
    always_comb begin
        upd_state_next = upd_state;
        if (upd_taken) begin
            if (upd_state != strong_taken) begin
                upd_state_next = ctr_state_t'(upd_state + 2'd1);
            end
        end else begin
            if (upd_state != strong_not_taken) begin
                upd_state_next = ctr_state_t'(upd_state - 2'd1);
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < entries; i++) begin
                ctr_mem[i] <= ctr_reset;
            end
        end else if (upd_en) begin
            ctr_mem[upd_index] <= upd_state_next;
        end
    end

    // Direction bit at the lookup index
    assign rd_taken = ctr_mem[rd_index][1];

    // Direction bit at the update index, before this edge
    assign upd_pred = upd_state[1];

endmodule

`default_nettype wire

//--- logic/history_table.sv
`timescale 1ns/100ps
`default_nettype none

// Per-slot local branch history
// One shift register per slot, newest outcome in bit 0
module history_table (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      upd_en,
    input  logic [bp_pkg::slot_w-1:0] pred_slot,
    input  logic [bp_pkg::slot_w-1:0] upd_slot,
    input  logic                      upd_taken,
    output logic [bp_pkg::hist_w-1:0] pred_hist,
    output logic [bp_pkg::hist_w-1:0] upd_hist
);

    import bp_pkg::*;

    // History storage
    logic [hist_w-1:0] hist_mem [num_slots];

    // Value the update slot takes after the shift
    logic [hist_w-1:0] upd_hist_next;

    // Oldest outcome drops off the top, new one enters at the bottom
    assign upd_hist_next = {hist_mem[upd_slot][hist_w-2:0], upd_taken};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < num_slots; i++) begin
                hist_mem[i] <= '0; // No history seen yet
            end
        end else if (upd_en) begin
            hist_mem[upd_slot] <= upd_hist_next;
        end
    end

    // Read port for the prediction lookup
    assign pred_hist = hist_mem[pred_slot];

    // Read port for the update side
    // Gives the history before this cycle's shift, which is what
    // the local pattern table must be trained with
    assign upd_hist = hist_mem[upd_slot];

endmodule

`default_nettype wire

//--- logic/predictor_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

// Index generation, update control and final selection
// for the tournament predictor
module predictor_ctrl (
    input  logic                          valid,
    input  logic                          actual_taken,
    input  logic [bp_pkg::pc_w-1:0]       predict_pc,
    input  logic [bp_pkg::pc_w-1:0]       update_pc,
    input  logic [bp_pkg::hist_w-1:0]     pred_hist,
    input  logic [bp_pkg::hist_w-1:0]     upd_hist,
    input  logic                          local_rd_taken,
    input  logic                          local_upd_pred,
    input  logic                          bim_rd_taken,
    input  logic                          bim_upd_pred,
    input  logic                          chooser_rd_taken,
    output logic [bp_pkg::slot_w-1:0]     pred_slot,
    output logic [bp_pkg::slot_w-1:0]     upd_slot,
    output logic [bp_pkg::lpht_idx_w-1:0] local_rd_index,
    output logic [bp_pkg::lpht_idx_w-1:0] local_upd_index,
    output logic                          hist_upd_en,
    output logic                          local_upd_en,
    output logic                          bim_upd_en,
    output logic                          chooser_upd_en,
    output logic                          chooser_upd_taken,
    output logic                          prediction
);

    import bp_pkg::*;

    // Correctness of the local component on the retiring branch
    logic local_correct;
    logic predictors_disagree;

    // Low PC bits pick the branch slot directly
    assign pred_slot = predict_pc[slot_w-1:0];
    assign upd_slot  = update_pc[slot_w-1:0];

    // Local pattern index is slot in the upper bits, history below
    assign local_rd_index  = {pred_slot, pred_hist};
    assign local_upd_index = {upd_slot, upd_hist}; // Pre-shift history

    // History, local and bimodal tables train on every valid cycle
    assign hist_upd_en  = valid;
    assign local_upd_en = valid;
    assign bim_upd_en   = valid;

    // Compare the local component against the resolved outcome
    assign local_correct = (local_upd_pred == actual_taken);

    // When both agree they are both right or both wrong,
    // so the chooser learns nothing from that branch
    assign predictors_disagree = (local_upd_pred != bim_upd_pred);

    // On disagreement exactly one side was right,
    // so the step goes toward local exactly when local was right
    assign chooser_upd_en    = valid && predictors_disagree;
    assign chooser_upd_taken = local_correct;

    // Chooser upper bit set means trust local
    assign prediction = chooser_rd_taken ? local_rd_taken : bim_rd_taken;

endmodule

`default_nettype wire

//--- logic/tournament_predictor.sv
`timescale 1ns/100ps
`default_nettype none

// Tournament branch predictor
// Local history predictor and bimodal predictor with a per-slot chooser
module tournament_predictor (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    valid,
    input  logic                    actual_taken,
    input  logic [bp_pkg::pc_w-1:0] predict_pc,
    input  logic [bp_pkg::pc_w-1:0] update_pc,
    output logic                    prediction
);

    import bp_pkg::*;

    // Slots and histories
    logic [slot_w-1:0]     pred_slot;
    logic [slot_w-1:0]     upd_slot;
    logic [hist_w-1:0]     pred_hist;
    logic [hist_w-1:0]     upd_hist;

    // Local pattern table indices
    logic [lpht_idx_w-1:0] local_rd_index;
    logic [lpht_idx_w-1:0] local_upd_index;

    // Table outputs
    logic                  local_rd_taken;
    logic                  local_upd_pred;
    logic                  bim_rd_taken;
    logic                  bim_upd_pred;
    logic                  chooser_rd_taken;

    // Update controls
    logic                  hist_upd_en;
    logic                  local_upd_en;
    logic                  bim_upd_en;
    logic                  chooser_upd_en;
    logic                  chooser_upd_taken;

    predictor_ctrl i_predictor_ctrl (
        .valid             (valid),
        .actual_taken      (actual_taken),
        .predict_pc        (predict_pc),
        .update_pc         (update_pc),
        .pred_hist         (pred_hist),
        .upd_hist          (upd_hist),
        .local_rd_taken    (local_rd_taken),
        .local_upd_pred    (local_upd_pred),
        .bim_rd_taken      (bim_rd_taken),
        .bim_upd_pred      (bim_upd_pred),
        .chooser_rd_taken  (chooser_rd_taken),
        .pred_slot         (pred_slot),
        .upd_slot          (upd_slot),
        .local_rd_index    (local_rd_index),
        .local_upd_index   (local_upd_index),
        .hist_upd_en       (hist_upd_en),
        .local_upd_en      (local_upd_en),
        .bim_upd_en        (bim_upd_en),
        .chooser_upd_en    (chooser_upd_en),
        .chooser_upd_taken (chooser_upd_taken),
        .prediction        (prediction)
    );

    history_table i_history_table (
        .clk       (clk),
        .rst       (rst),
        .upd_en    (hist_upd_en),
        .pred_slot (pred_slot),
        .upd_slot  (upd_slot),
        .upd_taken (actual_taken),
        .pred_hist (pred_hist),
        .upd_hist  (upd_hist)
    );

    // Indexed by {slot, local history}
    counter_table #(.idx_w(lpht_idx_w)) local_pht (
        .clk       (clk),
        .rst       (rst),
        .upd_en    (local_upd_en),
        .rd_index  (local_rd_index),
        .upd_index (local_upd_index),
        .upd_taken (actual_taken),
        .rd_taken  (local_rd_taken),
        .upd_pred  (local_upd_pred)
    );

    // Indexed by slot alone
    counter_table #(.idx_w(slot_w)) bimodal_pht (
        .clk       (clk),
        .rst       (rst),
        .upd_en    (bim_upd_en),
        .rd_index  (pred_slot),
        .upd_index (upd_slot),
        .upd_taken (actual_taken),
        .rd_taken  (bim_rd_taken),
        .upd_pred  (bim_upd_pred)
    );

    // Update-side direction of the chooser is never needed
    counter_table #(.idx_w(slot_w)) chooser (
        .clk       (clk),
        .rst       (rst),
        .upd_en    (chooser_upd_en),
        .rd_index  (pred_slot),
        .upd_index (upd_slot),
        .upd_taken (chooser_upd_taken),
        .rd_taken  (chooser_rd_taken),
        .upd_pred  ()
    );

endmodule

`default_nettype wire

//--- project.f
logic/bp_pkg.sv
logic/history_table.sv
logic/counter_table.sv
logic/predictor_ctrl.sv
logic/tournament_predictor.sv
verif/predictor_checker.sv
verif/tb_predictor.sv

//--- verif/predictor_checker.sv
`timescale 1ns/100ps
`default_nettype none

// Behavioral model of the tournament predictor
// Compares the DUT prediction after every edge and every lookup change
module predictor_checker (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    valid,
    input  logic                    actual_taken,
    input  logic [bp_pkg::pc_w-1:0] predict_pc,
    input  logic [bp_pkg::pc_w-1:0] update_pc,
    input  logic                    prediction,
    output int                      error_count,
    output int                      check_count
);

    import bp_pkg::*;

    // Model state, counters kept as plain 2-bit values
    logic [hist_w-1:0] hist_m [num_slots];
    logic [1:0]        local_m [2**lpht_idx_w];
    logic [1:0]        bim_m [num_slots];
    logic [1:0]        cho_m [num_slots];

    int errors = 0;
    int checks = 0;

    assign error_count = errors;
    assign check_count = checks;

    // One saturating step of a 2-bit counter, 0 and 3 are the limits
    function automatic logic [1:0] step_counter(input logic [1:0] cnt, input logic up);
        logic [1:0] nxt;
        nxt = cnt;
        if (up && cnt != 2'd3) begin
            nxt = cnt + 2'd1;
        end else if (!up && cnt != 2'd0) begin
            nxt = cnt - 2'd1;
        end
        return nxt;
    endfunction

    // Expected prediction for a lookup PC, from the model state
    function automatic logic expected_prediction(input logic [pc_w-1:0] pc);
        logic [slot_w-1:0]     slot;
        logic [lpht_idx_w-1:0] idx;
        logic                  dir;
        slot = pc[slot_w-1:0];
        idx  = {slot, hist_m[slot]};
        if (cho_m[slot][1]) begin
            dir = local_m[idx][1]; // Chooser trusts local
        end else begin
            dir = bim_m[slot][1];
        end
        return dir;
    endfunction

    always @(posedge clk or posedge rst) begin : model_update
        logic [slot_w-1:0]     slot;
        logic [lpht_idx_w-1:0] idx;
        logic                  local_dir;
        logic                  bim_dir;
        if (rst) begin
            for (int i = 0; i < num_slots; i++) begin
                hist_m[i] = '0;
                bim_m[i]  = 2'd1; // Weakly not taken
                cho_m[i]  = 2'd1; // Leans to bimodal
            end
            for (int i = 0; i < 2**lpht_idx_w; i++) begin
                local_m[i] = 2'd1;
            end
        end else if (valid) begin
            slot      = update_pc[slot_w-1:0];
            idx       = {slot, hist_m[slot]}; // History before the shift
            local_dir = local_m[idx][1];
            bim_dir   = bim_m[slot][1];
            // Chooser learns only when the two components disagree
            if (local_dir != bim_dir) begin
                cho_m[slot] = step_counter(cho_m[slot], local_dir == actual_taken);
            end
            local_m[idx] = step_counter(local_m[idx], actual_taken);
            bim_m[slot]  = step_counter(bim_m[slot], actual_taken);
            hist_m[slot] = {hist_m[slot][hist_w-2:0], actual_taken};
        end
    end

    // Sample a little after each edge and after each lookup change
    always begin
        @(posedge clk or predict_pc);
        #1;
        if (!rst) begin
            checks++;
            if (prediction !== expected_prediction(predict_pc)) begin
                errors++;
                $display("Fail prediction at %0t: pc 0x%0h expected 0x%0h actual 0x%0h",
                         $time, predict_pc, expected_prediction(predict_pc), prediction);
            end
        end
    end

endmodule

`default_nettype wire

//--- verif/tb_predictor.sv
`timescale 1ns/100ps
`default_nettype none

// Testbench top for the tournament predictor
module tb_predictor;

    import bp_pkg::*;

    logic            clk;
    logic            rst;
    logic            valid;
    logic            actual_taken;
    logic [pc_w-1:0] predict_pc;
    logic [pc_w-1:0] update_pc;
    logic            prediction;

    int              cycle_count = 0;
    int              seed = 30;
    int              tb_errors = 0;
    int              chk_errors;
    int              chk_count;
    logic [31:0]     rnd;

    // Small PC set, entries 2 and 3 alias on slot 0x13
    logic [pc_w-1:0] pc_set [8] = '{
        32'h0000_0105, 32'h0000_2009, 32'h0000_0013, 32'h0000_4013,
        32'h0000_0021, 32'h0000_003f, 32'h1000_0000, 32'h0000_0c2a
    };

    tournament_predictor i_tournament_predictor (
        .clk          (clk),
        .rst          (rst),
        .valid        (valid),
        .actual_taken (actual_taken),
        .predict_pc   (predict_pc),
        .update_pc    (update_pc),
        .prediction   (prediction)
    );

    predictor_checker i_predictor_checker (
        .clk          (clk),
        .rst          (rst),
        .valid        (valid),
        .actual_taken (actual_taken),
        .predict_pc   (predict_pc),
        .update_pc    (update_pc),
        .prediction   (prediction),
        .error_count  (chk_errors),
        .check_count  (chk_count)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk; // 4 ns period
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    // Wait n clock edges, give up if the cycle counter stalls
    task automatic wait_cycles(input int n);
        int target;
        int guard;
        target = cycle_count + n;
        guard  = 0;
        while (cycle_count < target && guard <= n + 4) begin
            @(posedge clk);
            guard++;
        end
        if (cycle_count < target) begin
            $display("Timeout: waited for %0d clock cycles but they did not complete", n);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    endtask

    // One retiring branch, then an idle cycle so the result is visible
    task automatic apply_update(input logic [pc_w-1:0] pc, input logic taken);
        valid        <= 1'b1;
        update_pc    <= pc;
        actual_taken <= taken;
        wait_cycles(1);
        valid <= 1'b0;
        wait_cycles(1);
    endtask

    task automatic look_up(input logic [pc_w-1:0] pc);
        predict_pc <= pc;
        wait_cycles(1);
    endtask

    task automatic expect_prediction(input logic exp, input string what);
        if (prediction !== exp) begin
            tb_errors++;
            $display("Fail prediction (%s): pc 0x%0h expected 0x%0h actual 0x%0h",
                     what, predict_pc, exp, prediction);
        end
    endtask

    initial begin
        rst          = 1'b1;
        valid        = 1'b0;
        actual_taken = 1'b0;
        predict_pc   = '0;
        update_pc    = '0;
        wait_cycles(5);
        rst <= 1'b0;
        wait_cycles(1);

        // Every slot predicts not taken out of reset
        for (int i = 0; i < num_slots; i++) begin
            look_up(32'h0000_8000 + i);
            expect_prediction(1'b0, "reset sweep");
        end

        // Always-taken branch on slot 5 through the bimodal path
        look_up(pc_set[0]);
        expect_prediction(1'b0, "untrained");
        apply_update(pc_set[0], 1'b1);
        expect_prediction(1'b1, "one taken update");
        for (int i = 0; i < 5; i++) begin
            apply_update(pc_set[0], 1'b1);
        end
        expect_prediction(1'b1, "saturated taken");
        apply_update(pc_set[0], 1'b0);
        expect_prediction(1'b1, "first not-taken only weakens");
        apply_update(pc_set[0], 1'b0);
        expect_prediction(1'b0, "second not-taken flips");

        // Alternating branch on slot 9, bimodal is always wrong
        look_up(pc_set[1]);
        expect_prediction(1'b0, "alternating first taken");
        for (int i = 0; i < 32; i++) begin
            apply_update(pc_set[1], (i % 2) == 0);
        end
        for (int i = 0; i < 8; i++) begin
            expect_prediction((i % 2) == 0, "alternating trained");
            apply_update(pc_set[1], (i % 2) == 0);
        end

        // Aliasing PCs share every entry
        look_up(pc_set[3]);
        expect_prediction(1'b0, "alias untrained");
        apply_update(pc_set[2], 1'b1);
        apply_update(pc_set[2], 1'b1);
        expect_prediction(1'b1, "alias sees other pc");
        apply_update(pc_set[3], 1'b0);
        apply_update(pc_set[3], 1'b0);
        look_up(pc_set[2]);
        expect_prediction(1'b0, "alias trained back");

        // Predict and update the same slot in one cycle
        predict_pc   <= pc_set[4];
        valid        <= 1'b1;
        update_pc    <= pc_set[4];
        actual_taken <= 1'b1;
        wait_cycles(1);
        expect_prediction(1'b0, "same slot before edge");
        valid <= 1'b0;
        wait_cycles(1);
        expect_prediction(1'b1, "same slot after edge");

        // Random stream, compared by the checker every cycle
        for (int i = 0; i < 2000; i++) begin
            rnd = $random(seed);
            valid        <= rnd[0];
            actual_taken <= rnd[1];
            update_pc    <= pc_set[rnd[4:2]];
            predict_pc   <= pc_set[rnd[7:5]];
            wait_cycles(1);
        end
        valid <= 1'b0;
        wait_cycles(2);

        $display("Checks %0d, checker errors %0d, testbench errors %0d",
                 chk_count, chk_errors, tb_errors);
        if (chk_errors == 0 && tb_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
